// File: axi_ram.f
design/axi_ram_pkg.sv
design/axi_burst_addr.sv
design/axi_slave_ram.sv
design/spsram_bank.sv
design/axi_ram_top.sv
bench/tb_axi_ram.sv

// File: bench/tb_axi_ram.sv
`timescale 1ns/100ps

module tb_axi_ram;

  typedef struct packed {
    logic [1:0]          op;
    logic [31:0]         addr;
    axi_ram_pkg::burst_e burst;
    logic [7:0]          len;
    logic [7:0]          id;
    logic [15:0]         strb;
    logic [3:0]          gap;
  } row_t;

  localparam logic [1:0] op_wr   = 2'd0;
  localparam logic [1:0] op_rd   = 2'd1;
  localparam logic [1:0] op_rdwr = 2'd2;

  logic                 pll_core_cpuclk = 1'b0;
  logic                 pad_cpu_rst;
  axi_ram_pkg::ax_req_t ar;
  logic                 arvalid;
  logic                 arready;
  axi_ram_pkg::ax_req_t aw;
  logic                 awvalid;
  logic                 awready;
  axi_ram_pkg::w_beat_t w;
  logic                 wvalid;
  logic                 wready;
  axi_ram_pkg::r_beat_t r;
  logic                 rvalid;
  logic                 rready;
  axi_ram_pkg::b_resp_t b;
  logic                 bvalid;
  logic                 bready;

  row_t       rows[$];
  logic [7:0] ref_mem [logic [31:0]];
  int         err_cnt = 0;
  int         err_start;
  int         pass_rows = 0;
  int         fail_rows = 0;
  int         total_beats = 0;
  int         cycle_cnt = 0;
  int         cycle_limit = 0;

  axi_ram_top #(
    .mem_aw (16)
  ) i_dut (
    .pll_core_cpuclk (pll_core_cpuclk),
    .pad_cpu_rst     (pad_cpu_rst),
    .ar              (ar),
    .arvalid         (arvalid),
    .arready         (arready),
    .aw              (aw),
    .awvalid         (awvalid),
    .awready         (awready),
    .w               (w),
    .wvalid          (wvalid),
    .wready          (wready),
    .r               (r),
    .rvalid          (rvalid),
    .rready          (rready),
    .b               (b),
    .bvalid          (bvalid),
    .bready          (bready)
  );

  always #20 pll_core_cpuclk = ~pll_core_cpuclk;

  always @(posedge pll_core_cpuclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [159:0] got, input logic [159:0] exp);
    if (got !== exp)
    begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_row(input logic [1:0] op, input logic [31:0] addr,
                         input axi_ram_pkg::burst_e burst, input logic [7:0] len,
                         input logic [7:0] id, input logic [15:0] strb, input logic [3:0] gap);
    rows.push_back({op, addr, burst, len, id, strb, gap});
  endtask

  // wrap bursts of 2 and 4 beats stay inside their aligned window.
  function automatic logic [31:0] expected_addr(input logic [31:0] start,
                                                input axi_ram_pkg::burst_e kind,
                                                input logic [7:0] len, input int unsigned k);
    logic [31:0] win;
    logic [31:0] base;
    if (kind == axi_ram_pkg::burst_wrap && (len == 8'd1 || len == 8'd3))
    begin
      win  = (32'(len) + 32'd1) * 32'd16;
      base = start & ~(win - 32'd1);
      return base + ((start - base + 32'(k) * 32'd16) % win);
    end
    return start + 32'(k) * 32'd16;
  endfunction

  function automatic logic [127:0] expected_beat(input logic [31:0] a);
    logic [127:0] d;
    int           j;
    d = '0;
    for (j = 0; j < 16; j++)
      d[j*8 +: 8] = ref_mem[a + 32'(j)];
    return d;
  endfunction

  function automatic axi_ram_pkg::ax_req_t make_req(input row_t rw);
    axi_ram_pkg::ax_req_t req;
    req       = '0;
    req.addr  = rw.addr;
    req.burst = rw.burst;
    req.id    = rw.id;
    req.len   = rw.len;
    req.size  = 3'd4;
    return req;
  endfunction

  function automatic logic next_ready(input logic [3:0] gap);
    if (gap == 4'd0)
      return 1'b1;
    return ($urandom % (32'(gap) + 32'd1)) == 32'd0;
  endfunction

  function automatic logic [127:0] rand128();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // with aw_pending the aw channel is raised together with ar.
  task automatic read_burst(input row_t rw, input logic aw_pending);
    int unsigned  k;
    int           wait_n;
    logic         stalled;
    logic [159:0] held;
    @(posedge pll_core_cpuclk);
    ar      <= make_req(rw);
    arvalid <= 1'b1;
    if (aw_pending)
    begin
      aw      <= make_req(rw);
      awvalid <= 1'b1;
    end
    @(negedge pll_core_cpuclk);
    // an idle controller takes the read address in the cycle it appears.
    check_val("arready", 160'(arready), 160'(1));
    while (!arready)
    begin
      @(posedge pll_core_cpuclk);
      @(negedge pll_core_cpuclk);
    end
    if (aw_pending)
      check_val("awready", 160'(awready), 160'(0));
    @(posedge pll_core_cpuclk);
    arvalid <= 1'b0;
    rready  <= next_ready(rw.gap);
    k       = 0;
    wait_n  = 0;
    stalled = 1'b0;
    while (k <= 32'(rw.len))
    begin
      @(negedge pll_core_cpuclk);
      wait_n++;
      if (aw_pending)
        check_val("awready", 160'(awready), 160'(0));
      if (rvalid)
      begin
        if (stalled)
          check_val("r", 160'(r), held);
        else
          check_val("rvalid delay", 160'(wait_n), 160'(2));
        if (rready)
        begin
          check_val("rdata", 160'(r.data),
                    160'(expected_beat(expected_addr(rw.addr, rw.burst, rw.len, k))));
          check_val("rlast", 160'(r.last), 160'(k == 32'(rw.len)));
          check_val("rid", 160'(r.id), 160'(rw.id));
          check_val("rresp", 160'(r.resp), 160'(axi_ram_pkg::resp_okay));
          k++;
          wait_n  = 0;
          stalled = 1'b0;
        end
        else
        begin
          held    = 160'(r);
          stalled = 1'b1;
        end
      end
      else if (stalled)
      begin
        $display("rvalid dropped before beat %0d was taken", k);
        err_cnt++;
        stalled = 1'b0;
      end
      @(posedge pll_core_cpuclk);
      rready <= next_ready(rw.gap);
    end
    rready <= 1'b0;
    // a repeated beat would show up here.
    if (!aw_pending)
    begin
      repeat (2)
      begin
        @(negedge pll_core_cpuclk);
        check_val("rvalid", 160'(rvalid), 160'(0));
      end
    end
  endtask

  task automatic write_burst(input row_t rw, input logic aw_pending);
    int unsigned          k;
    int                   j;
    int                   wait_n;
    logic                 stalled;
    logic                 done;
    logic [159:0]         held;
    logic [31:0]          ba;
    axi_ram_pkg::w_beat_t wb;
    if (!aw_pending)
    begin
      @(posedge pll_core_cpuclk);
      aw      <= make_req(rw);
      awvalid <= 1'b1;
    end
    @(negedge pll_core_cpuclk);
    check_val("awready", 160'(awready), 160'(1));
    while (!awready)
    begin
      @(posedge pll_core_cpuclk);
      @(negedge pll_core_cpuclk);
    end
    @(posedge pll_core_cpuclk);
    awvalid <= 1'b0;
    for (k = 0; k <= 32'(rw.len); k++)
    begin
      ba      = expected_addr(rw.addr, rw.burst, rw.len, k);
      wb.data = rand128();
      wb.strb = rw.strb;
      wb.last = (k == 32'(rw.len));
      for (j = 0; j < 16; j++)
        if (rw.strb[j])
          ref_mem[ba + 32'(j)] = wb.data[j*8 +: 8];
      w      <= wb;
      wvalid <= 1'b1;
      @(negedge pll_core_cpuclk);
      // wready stays high for the whole write burst.
      check_val("wready", 160'(wready), 160'(1));
      while (!wready)
      begin
        @(posedge pll_core_cpuclk);
        @(negedge pll_core_cpuclk);
      end
      @(posedge pll_core_cpuclk);
    end
    wvalid  <= 1'b0;
    bready  <= next_ready(rw.gap);
    wait_n  = 0;
    stalled = 1'b0;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge pll_core_cpuclk);
      wait_n++;
      if (bvalid)
      begin
        if (stalled)
          check_val("b", 160'(b), held);
        else
          check_val("bvalid delay", 160'(wait_n), 160'(1));
        if (bready)
        begin
          check_val("bid", 160'(b.id), 160'(rw.id));
          check_val("bresp", 160'(b.resp), 160'(axi_ram_pkg::resp_okay));
          done = 1'b1;
        end
        else
        begin
          held    = 160'(b);
          stalled = 1'b1;
        end
      end
      else if (stalled)
      begin
        $display("bvalid dropped before the write response was taken");
        err_cnt++;
        stalled = 1'b0;
      end
      @(posedge pll_core_cpuclk);
      bready <= next_ready(rw.gap);
    end
    bready <= 1'b0;
  endtask

  initial
  begin
    pad_cpu_rst <= 1'b1;
    ar          <= '0;
    arvalid     <= 1'b0;
    aw          <= '0;
    awvalid     <= 1'b0;
    w           <= '0;
    wvalid      <= 1'b0;
    rready      <= 1'b0;
    bready      <= 1'b0;
    void'($urandom(32'h8231_3276));

    add_row(op_wr,   32'h100, axi_ram_pkg::burst_incr, 8'd3, 8'h11, 16'hffff, 4'd0);
    add_row(op_rd,   32'h100, axi_ram_pkg::burst_incr, 8'd3, 8'h12, 16'hffff, 4'd0);
    add_row(op_wr,   32'h100, axi_ram_pkg::burst_incr, 8'd3, 8'h21, 16'ha5c3, 4'd2);
    add_row(op_rd,   32'h100, axi_ram_pkg::burst_incr, 8'd3, 8'h22, 16'hffff, 4'd2);
    add_row(op_wr,   32'h200, axi_ram_pkg::burst_incr, 8'd3, 8'h31, 16'hffff, 4'd0);
    add_row(op_wr,   32'h230, axi_ram_pkg::burst_wrap, 8'd3, 8'h32, 16'hffff, 4'd1);
    add_row(op_rd,   32'h200, axi_ram_pkg::burst_incr, 8'd3, 8'h33, 16'hffff, 4'd0);
    add_row(op_wr,   32'h300, axi_ram_pkg::burst_incr, 8'd1, 8'h41, 16'hffff, 4'd0);
    add_row(op_wr,   32'h310, axi_ram_pkg::burst_wrap, 8'd1, 8'h42, 16'h0f0f, 4'd0);
    add_row(op_rd,   32'h300, axi_ram_pkg::burst_incr, 8'd1, 8'h43, 16'hffff, 4'd3);
    add_row(op_rd,   32'h220, axi_ram_pkg::burst_wrap, 8'd3, 8'h44, 16'hffff, 4'd1);
    add_row(op_rdwr, 32'h100, axi_ram_pkg::burst_incr, 8'd3, 8'h51, 16'hffff, 4'd1);
    add_row(op_rd,   32'h100, axi_ram_pkg::burst_incr, 8'd3, 8'h52, 16'hffff, 4'd2);
    add_row(op_wr,   32'h500, axi_ram_pkg::burst_incr, 8'd7, 8'h61, 16'hffff, 4'd3);
    add_row(op_rd,   32'h500, axi_ram_pkg::burst_incr, 8'd7, 8'h62, 16'hffff, 4'd3);
    add_row(op_wr,   32'h600, axi_ram_pkg::burst_incr, 8'd0, 8'h71, 16'hffff, 4'd0);
    add_row(op_rd,   32'h600, axi_ram_pkg::burst_incr, 8'd0, 8'h72, 16'hffff, 4'd0);

    foreach (rows[i])
      total_beats += (int'(rows[i].len) + 1) * ((rows[i].op == op_rdwr) ? 2 : 1);
    cycle_limit = 20 * total_beats + 200;

    repeat (16) @(posedge pll_core_cpuclk);
    pad_cpu_rst <= 1'b0;
    repeat (2) @(posedge pll_core_cpuclk);

    foreach (rows[i])
    begin
      err_start = err_cnt;
      if (rows[i].op != op_wr)
        read_burst(rows[i], rows[i].op == op_rdwr);
      if (rows[i].op != op_rd)
        write_burst(rows[i], rows[i].op == op_rdwr);
      if (err_cnt == err_start)
        pass_rows++;
      else
        fail_rows++;
      $display("test %0d op %0d addr 0x%h beats %0d finished with %0d errors", i,
               rows[i].op, rows[i].addr, int'(rows[i].len) + 1, err_cnt - err_start);
    end

    $display("tests passed %0d, tests failed %0d", pass_rows, fail_rows);
    if (fail_rows == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: design/axi_burst_addr.sv
`timescale 1ns/100ps

module axi_burst_addr #(
  parameter int mem_aw = 16
) (
  input  logic                              pll_core_cpuclk,
  input  logic                              pad_cpu_rst,
  input  logic [axi_ram_pkg::addr_w-1:0]    ar_addr,
  input  logic [axi_ram_pkg::addr_w-1:0]    aw_addr,
  input  logic                              addr_load,
  input  logic                              addr_src_read,
  input  logic                              beat_adv,
  input  axi_ram_pkg::burst_e               burst_kind,
  input  logic [axi_ram_pkg::len_w-1:0]     burst_len,
  output logic [mem_aw-1:0]                 ram_index
);

  localparam int lsb = $clog2(axi_ram_pkg::beat_bytes);

  logic [axi_ram_pkg::addr_w-1:0] beat_addr;
  logic [axi_ram_pkg::addr_w-1:0] incr_addr;
  logic [axi_ram_pkg::addr_w-1:0] next_addr;
  logic [axi_ram_pkg::addr_w-1:0] wrap_mask;
  logic [axi_ram_pkg::len_w-1:0]  beat_cnt;
  logic                           wrap_on;

  assign incr_addr = beat_addr + axi_ram_pkg::addr_w'(axi_ram_pkg::beat_bytes);

  // only 2 and 4 beat wraps are supported, anything else runs as incr.
  always_comb
  begin
    wrap_on   = 1'b0;
    wrap_mask = axi_ram_pkg::addr_w'(4 * axi_ram_pkg::beat_bytes - 1);
    if (burst_kind == axi_ram_pkg::burst_wrap)
    begin
      if (burst_len == axi_ram_pkg::len_w'(1))
      begin
        wrap_on   = 1'b1;
        wrap_mask = axi_ram_pkg::addr_w'(2 * axi_ram_pkg::beat_bytes - 1);
      end
      else if (burst_len == axi_ram_pkg::len_w'(3))
      begin
        wrap_on = 1'b1;
      end
    end
  end

  // keep the window base, step only inside the window.
  assign next_addr = wrap_on ? ((beat_addr & ~wrap_mask) | (incr_addr & wrap_mask))
                             : incr_addr;

  always_ff @(posedge pll_core_cpuclk or posedge pad_cpu_rst)
  begin
    if (pad_cpu_rst)
    begin
      beat_addr <= '0;
      beat_cnt  <= '0;
    end
    else if (addr_load)
    begin
      beat_addr <= addr_src_read ? ar_addr : aw_addr;
      beat_cnt  <= '0;
    end
    else if (beat_adv && (beat_cnt != burst_len))
    begin
      // address holds on the final beat.
      beat_addr <= next_addr;
      beat_cnt  <= beat_cnt + 1'b1;
    end
  end

  assign ram_index = beat_addr[lsb +: mem_aw];

endmodule

// File: design/axi_ram_pkg.sv
package axi_ram_pkg;

  // bus widths.
  localparam int addr_w     = 32;
  localparam int data_w     = 128;
  localparam int strb_w     = data_w / 8;
  localparam int beat_bytes = 16;
  localparam int id_w       = 8;
  localparam int len_w      = 8;

  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } burst_e;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef enum logic [1:0] {
    st_idle       = 2'b00,
    st_write      = 2'b01,
    st_write_resp = 2'b10,
    st_read       = 2'b11
  } ram_state_e;

  // shared by the ar and aw channels.
  typedef struct packed {
    logic [addr_w-1:0] addr;
    burst_e            burst;
    logic [id_w-1:0]   id;
    logic [len_w-1:0]  len;
    logic [2:0]        size;
    logic [3:0]        cache;
    logic [2:0]        prot;
  } ax_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } w_beat_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [id_w-1:0]   id;
    logic [1:0]        resp;
    logic              last;
  } r_beat_t;

  typedef struct packed {
    logic [id_w-1:0] id;
    logic [1:0]      resp;
  } b_resp_t;

endpackage

// File: design/axi_ram_top.sv
`timescale 1ns/100ps

module axi_ram_top #(
  parameter int mem_aw = 16
) (
  input  logic                 pll_core_cpuclk,
  input  logic                 pad_cpu_rst,
  input  axi_ram_pkg::ax_req_t ar,
  input  logic                 arvalid,
  output logic                 arready,
  input  axi_ram_pkg::ax_req_t aw,
  input  logic                 awvalid,
  output logic                 awready,
  input  axi_ram_pkg::w_beat_t w,
  input  logic                 wvalid,
  output logic                 wready,
  output axi_ram_pkg::r_beat_t r,
  output logic                 rvalid,
  input  logic                 rready,
  output axi_ram_pkg::b_resp_t b,
  output logic                 bvalid,
  input  logic                 bready
);

  logic                            addr_load;
  logic                            addr_src_read;
  logic                            beat_adv;
  axi_ram_pkg::burst_e             burst_kind;
  logic [axi_ram_pkg::len_w-1:0]   burst_len;
  logic [mem_aw-1:0]               ram_index;
  logic                            ram_cen;
  logic [axi_ram_pkg::strb_w-1:0]  ram_wen;
  logic [axi_ram_pkg::data_w-1:0]  ram_din;
  logic [axi_ram_pkg::data_w-1:0]  ram_dout;
  logic [63:0]                     dout_lo;
  logic [63:0]                     dout_hi;

  axi_slave_ram u_ctrl (
    .pll_core_cpuclk (pll_core_cpuclk),
    .pad_cpu_rst     (pad_cpu_rst),
    .ar              (ar),
    .arvalid         (arvalid),
    .arready         (arready),
    .aw              (aw),
    .awvalid         (awvalid),
    .awready         (awready),
    .w               (w),
    .wvalid          (wvalid),
    .wready          (wready),
    .r               (r),
    .rvalid          (rvalid),
    .rready          (rready),
    .b               (b),
    .bvalid          (bvalid),
    .bready          (bready),
    .addr_load       (addr_load),
    .addr_src_read   (addr_src_read),
    .beat_adv        (beat_adv),
    .burst_kind      (burst_kind),
    .burst_len       (burst_len),
    .ram_cen         (ram_cen),
    .ram_wen         (ram_wen),
    .ram_din         (ram_din),
    .ram_dout        (ram_dout)
  );

  axi_burst_addr #(
    .mem_aw (mem_aw)
  ) u_addr (
    .pll_core_cpuclk (pll_core_cpuclk),
    .pad_cpu_rst     (pad_cpu_rst),
    .ar_addr         (ar.addr),
    .aw_addr         (aw.addr),
    .addr_load       (addr_load),
    .addr_src_read   (addr_src_read),
    .beat_adv        (beat_adv),
    .burst_kind      (burst_kind),
    .burst_len       (burst_len),
    .ram_index       (ram_index)
  );

  // low bank holds bytes 0 to 7 of each beat.
  spsram_bank #(
    .mem_aw (mem_aw)
  ) u_bank_lo (
    .pll_core_cpuclk (pll_core_cpuclk),
    .a               (ram_index),
    .cen             (ram_cen),
    .wen             (ram_wen[7:0]),
    .d               (ram_din[63:0]),
    .q               (dout_lo)
  );

  spsram_bank #(
    .mem_aw (mem_aw)
  ) u_bank_hi (
    .pll_core_cpuclk (pll_core_cpuclk),
    .a               (ram_index),
    .cen             (ram_cen),
    .wen             (ram_wen[15:8]),
    .d               (ram_din[127:64]),
    .q               (dout_hi)
  );

  assign ram_dout = {dout_hi, dout_lo};

endmodule

// File: design/axi_slave_ram.sv
`timescale 1ns/100ps

module axi_slave_ram (
  input  logic                              pll_core_cpuclk,
  input  logic                              pad_cpu_rst,
  input  axi_ram_pkg::ax_req_t              ar,
  input  logic                              arvalid,
  output logic                              arready,
  input  axi_ram_pkg::ax_req_t              aw,
  input  logic                              awvalid,
  output logic                              awready,
  input  axi_ram_pkg::w_beat_t              w,
  input  logic                              wvalid,
  output logic                              wready,
  output axi_ram_pkg::r_beat_t              r,
  output logic                              rvalid,
  input  logic                              rready,
  output axi_ram_pkg::b_resp_t              b,
  output logic                              bvalid,
  input  logic                              bready,
  output logic                              addr_load,
  output logic                              addr_src_read,
  output logic                              beat_adv,
  output axi_ram_pkg::burst_e               burst_kind,
  output logic [axi_ram_pkg::len_w-1:0]     burst_len,
  output logic                              ram_cen,
  output logic [axi_ram_pkg::strb_w-1:0]    ram_wen,
  output logic [axi_ram_pkg::data_w-1:0]    ram_din,
  input  logic [axi_ram_pkg::data_w-1:0]    ram_dout
);

  axi_ram_pkg::ram_state_e         state;
  axi_ram_pkg::ram_state_e         next_state;
  axi_ram_pkg::burst_e             burst_q;
  logic [axi_ram_pkg::id_w-1:0]    id_q;
  logic [axi_ram_pkg::len_w-1:0]   len_q;
  logic [axi_ram_pkg::len_w-1:0]   beat_cnt;
  logic                            last_beat;
  logic                            rst_done;
  logic                            rd_dly;
  logic                            ar_fire;
  logic                            aw_fire;
  logic                            w_fire;
  logic                            r_fire;
  logic                            b_fire;

  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign r_fire  = rvalid && rready;
  assign b_fire  = bvalid && bready;

  // holds the address channels off during the first cycle out of reset.
  always_ff @(posedge pll_core_cpuclk or posedge pad_cpu_rst)
  begin
    if (pad_cpu_rst)
      rst_done <= 1'b0;
    else
      rst_done <= 1'b1;
  end

  // reads take priority in idle.
  assign arready = (state == axi_ram_pkg::st_idle) && rst_done && arvalid;
  assign awready = (state == axi_ram_pkg::st_idle) && rst_done && !arvalid;
  assign wready  = (state == axi_ram_pkg::st_write);
  assign bvalid  = (state == axi_ram_pkg::st_write_resp);

  always_ff @(posedge pll_core_cpuclk or posedge pad_cpu_rst)
  begin
    if (pad_cpu_rst)
      state <= axi_ram_pkg::st_idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      axi_ram_pkg::st_idle:
      begin
        if (ar_fire)
          next_state = axi_ram_pkg::st_read;
        else if (aw_fire)
          next_state = axi_ram_pkg::st_write;
      end
      axi_ram_pkg::st_read:
      begin
        if (r_fire && last_beat)
          next_state = axi_ram_pkg::st_idle;
      end
      axi_ram_pkg::st_write:
      begin
        if (w_fire && last_beat)
          next_state = axi_ram_pkg::st_write_resp;
      end
      axi_ram_pkg::st_write_resp:
      begin
        if (b_fire)
          next_state = axi_ram_pkg::st_idle;
      end
      default:
      begin
        next_state = axi_ram_pkg::st_idle;
      end
    endcase
  end

  // request fields for the accepted burst.
  always_ff @(posedge pll_core_cpuclk)
  begin
    if (addr_load)
    begin
      id_q    <= ar_fire ? ar.id : aw.id;
      len_q   <= ar_fire ? ar.len : aw.len;
      burst_q <= ar_fire ? ar.burst : aw.burst;
    end
  end

  always_ff @(posedge pll_core_cpuclk or posedge pad_cpu_rst)
  begin
    if (pad_cpu_rst)
      beat_cnt <= '0;
    else if (addr_load)
      beat_cnt <= '0;
    else if (beat_adv)
      beat_cnt <= beat_cnt + 1'b1;
  end

  assign last_beat = (beat_cnt == len_q);

  assign addr_load     = ar_fire || aw_fire;
  assign addr_src_read = ar_fire;
  assign beat_adv      = r_fire || w_fire;
  assign burst_kind    = burst_q;
  assign burst_len     = len_q;

  // one cycle for the sram read, then rvalid.
  always_ff @(posedge pll_core_cpuclk or posedge pad_cpu_rst)
  begin
    if (pad_cpu_rst)
      rd_dly <= 1'b0;
    else
      rd_dly <= ar_fire || (r_fire && !last_beat);
  end

  always_ff @(posedge pll_core_cpuclk or posedge pad_cpu_rst)
  begin
    if (pad_cpu_rst)
      rvalid <= 1'b0;
    else if ((state == axi_ram_pkg::st_read) && rd_dly)
      rvalid <= 1'b1;
    else if (r_fire)
      rvalid <= 1'b0;
  end

  // the sram reads every cycle of a read burst, so q holds while stalled.
  always_comb
  begin
    ram_cen = 1'b1;
    ram_wen = '1;
    ram_din = w.data;
    if (state == axi_ram_pkg::st_read)
    begin
      ram_cen = 1'b0;
    end
    else if (w_fire)
    begin
      ram_cen = 1'b0;
      ram_wen = ~w.strb;
    end
  end

  assign r.data = ram_dout;
  assign r.id   = id_q;
  assign r.resp = axi_ram_pkg::resp_okay;
  assign r.last = last_beat;

  assign b.id   = id_q;
  assign b.resp = axi_ram_pkg::resp_okay;

endmodule

// File: design/spsram_bank.sv
`timescale 1ns/100ps

module spsram_bank #(
  parameter int mem_aw = 16
) (
  input  logic              pll_core_cpuclk,
  input  logic [mem_aw-1:0] a,
  input  logic              cen,
  input  logic [7:0]        wen,
  input  logic [63:0]       d,
  output logic [63:0]       q
);

  logic [63:0] mem [2**mem_aw];

  // byte lanes written where wen is low.
  always_ff @(posedge pll_core_cpuclk)
  begin
    if (!cen)
    begin
      for (int i = 0; i < 8; i++)
      begin
        if (!wen[i])
          mem[a][i*8 +: 8] <= d[i*8 +: 8];
      end
    end
  end

  // read returns the old word on a write cycle.
  always_ff @(posedge pll_core_cpuclk)
  begin
    if (!cen)
      q <= mem[a];
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the axi_ram testbench with verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_axi_ram -Mdir obj_dir -f axi_ram.f

./obj_dir/Vtb_axi_ram > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
